// File: verilog/deint_pkg.sv
`default_nettype none

package deint_pkg;

   // ----------------------------------------
   // sizes
   // ----------------------------------------
   localparam int DATA_WIDTH     = 64;                 // lane word
   localparam int CODE_WIDTH     = 72;                 // data + 7 hamming + overall parity
   localparam int ADDR_WIDTH     = 7;
   localparam int FIFO_DEPTH     = 1 << ADDR_WIDTH;    // 128 entries
   localparam int RAM_PIPE_STAGE = 2;                  // ram read data delay
   localparam int PRE_SLOT_NUM   = RAM_PIPE_STAGE + 2;
   localparam int LEVEL_WIDTH    = ADDR_WIDTH + 1;     // holds 0..FIFO_DEPTH

   // ----------------------------------------
   // write side error injection
   // ----------------------------------------
   typedef enum logic [1:0] {
      INJ_NONE   = 2'd0,
      INJ_SINGLE = 2'd1,   // flip codeword bit 0
      INJ_DOUBLE = 2'd2    // flip codeword bits 0 and 1
   } err_inject_e;

   // ----------------------------------------
   // bundles
   // ----------------------------------------
   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      err_inject_e           inject;
      logic                  en;       // write strobe
   } deint_wr_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;     // after correction
      logic                  single_err;
      logic                  double_err;
   } deint_rd_t;

   // programmable full thresholds, compared against the level
   typedef struct packed {
      logic [LEVEL_WIDTH-1:0] full_assert;
      logic [LEVEL_WIDTH-1:0] full_negate;
   } deint_cfg_t;

   typedef struct packed {
      logic full;
      logic prog_full;
      logic ovf_int;
      logic udf_int;
   } deint_status_t;

endpackage

`default_nettype wire

// File: verilog/deint_secded_enc.sv
`timescale 1ns/100ps
`default_nettype none

module deint_secded_enc
   import deint_pkg::*;
(
   input  deint_wr_t             wr,
   output logic [CODE_WIDTH-1:0] code
);

   logic [CODE_WIDTH-1:0] hcode;   // clean codeword

   // data on non power-of-two positions, hamming bits on powers of two
   always_comb begin
      int unsigned d;
      logic        par;
      hcode = '0;
      d     = 0;
      for (int p = 1; p < CODE_WIDTH; p++) begin
         if ((p & (p - 1)) != 0) begin
            hcode[p] = wr.data[d];
            d++;
         end
      end
      for (int k = 0; k < CODE_WIDTH - DATA_WIDTH - 1; k++) begin
         par = 1'b0;
         for (int p = 1; p < CODE_WIDTH; p++) begin
            if (p[k])
               par ^= hcode[p];
         end
         hcode[1 << k] = par;
      end
      hcode[0] = ^hcode[CODE_WIDTH-1:1];   // overall parity
   end

   always_comb begin
      case (wr.inject)
         INJ_SINGLE: code = hcode ^ CODE_WIDTH'(1);
         INJ_DOUBLE: code = hcode ^ CODE_WIDTH'(3);
         default:    code = hcode;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/deint_secded_dec.sv
`timescale 1ns/100ps
`default_nettype none

module deint_secded_dec
   import deint_pkg::*;
(
   input  logic [CODE_WIDTH-1:0] code,
   output deint_rd_t             word
);

   logic [CODE_WIDTH-DATA_WIDTH-2:0] syn;       // 7 bit syndrome
   logic                             par_odd;   // overall parity check fails
   logic [CODE_WIDTH-1:0]            fixed;

   // ----------------------------------------
   // syndrome
   // ----------------------------------------
   always_comb begin
      syn = '0;
      for (int p = 1; p < CODE_WIDTH; p++) begin
         for (int k = 0; k < CODE_WIDTH - DATA_WIDTH - 1; k++) begin
            if (p[k])
               syn[k] ^= code[p];
         end
      end
   end

   assign par_odd = ^code;

   // ----------------------------------------
   // classify, correct, extract
   // ----------------------------------------
   always_comb begin
      int unsigned d;
      fixed           = code;
      word.single_err = 1'b0;
      word.double_err = 1'b0;
      if (syn == '0) begin
         word.single_err = par_odd;          // overall parity bit alone
      end else if (!par_odd) begin
         word.double_err = 1'b1;             // two flips, data left as is
      end else if (syn < CODE_WIDTH) begin
         fixed[syn]      = ~code[syn];
         word.single_err = 1'b1;
      end else begin
         // syndrome points past the codeword, so more than one flip
         word.double_err = 1'b1;
      end

      word.data = '0;
      d         = 0;
      for (int p = 1; p < CODE_WIDTH; p++) begin
         if ((p & (p - 1)) != 0) begin
            word.data[d] = fixed[p];
            d++;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/deint_fifo_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module deint_fifo_ctrl
   import deint_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  wr_en,
   input  logic                  pop,
   input  logic                  fetch,
   input  deint_cfg_t            cfg,
   output logic                  wen,
   output logic [ADDR_WIDTH-1:0] waddr,
   output logic [ADDR_WIDTH-1:0] raddr,
   output logic                  avail,
   output logic                  full,
   output logic                  prog_full,
   output logic                  ovf_int
);

   logic [ADDR_WIDTH-1:0]  wptr;
   logic [ADDR_WIDTH-1:0]  fptr;
   logic [LEVEL_WIDTH-1:0] unfetched;   // in ram, not yet fetched
   logic [LEVEL_WIDTH-1:0] level;       // accepted, not yet popped
   logic [LEVEL_WIDTH-1:0] level_nxt;

   assign wen   = wr_en & ~full;        // drop writes while full
   assign waddr = wptr;
   assign raddr = fptr;
   assign avail = (unfetched != '0);

   // ----------------------------------------
   // pointers
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wptr <= '0;
         fptr <= '0;
      end else begin
         if (wen)
            wptr <= wptr + 1'b1;
         if (fetch)
            fptr <= fptr + 1'b1;
      end
   end

   // ----------------------------------------
   // counters
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         unfetched <= '0;
      end else begin
         case ({wen, fetch})
            2'b10:   unfetched <= unfetched + 1'b1;
            2'b01:   unfetched <= unfetched - 1'b1;
            default: unfetched <= unfetched;
         endcase
      end
   end

   always_comb begin
      case ({wen, pop})
         2'b10:   level_nxt = level + 1'b1;
         2'b01:   level_nxt = level - 1'b1;
         default: level_nxt = level;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         level <= '0;
      else
         level <= level_nxt;
   end

   // ----------------------------------------
   // flags
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full      <= 1'b0;
         prog_full <= 1'b0;
         ovf_int   <= 1'b0;
      end else begin
         full <= (level_nxt == LEVEL_WIDTH'(FIFO_DEPTH));
         // hysteresis between the two thresholds
         if (level_nxt >= cfg.full_assert)
            prog_full <= 1'b1;
         else if (level_nxt <= cfg.full_negate)
            prog_full <= 1'b0;
         ovf_int <= wr_en & full;        // one pulse per dropped write
      end
   end

endmodule

`default_nettype wire

// File: verilog/deint_ram.sv
`timescale 1ns/100ps
`default_nettype none

module deint_ram
   import deint_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  wen,
   input  logic [ADDR_WIDTH-1:0] waddr,
   input  logic [CODE_WIDTH-1:0] wdata,
   input  logic                  ren,
   input  logic [ADDR_WIDTH-1:0] raddr,
   output logic [CODE_WIDTH-1:0] rdata,
   output logic                  rdata_val
);

   logic [CODE_WIDTH-1:0]     mem [FIFO_DEPTH];
   logic [ADDR_WIDTH-1:0]     raddr_q;
   logic                      ren_q;
   logic [CODE_WIDTH-1:0]     pipe_data [RAM_PIPE_STAGE];
   logic [RAM_PIPE_STAGE-1:0] pipe_val;

   always_ff @(posedge clk) begin
      if (wen)
         mem[waddr] <= wdata;
   end

   always_ff @(posedge clk) begin
      if (ren)
         raddr_q <= raddr;                // read address held per request
      pipe_data[0] <= mem[raddr_q];
      for (int s = 1; s < RAM_PIPE_STAGE; s++)
         pipe_data[s] <= pipe_data[s-1];
   end

   // valid travels alongside the data stages
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ren_q    <= 1'b0;
         pipe_val <= '0;
      end else begin
         ren_q       <= ren;
         pipe_val[0] <= ren_q;
         for (int s = 1; s < RAM_PIPE_STAGE; s++)
            pipe_val[s] <= pipe_val[s-1];
      end
   end

   assign rdata     = pipe_data[RAM_PIPE_STAGE-1];
   assign rdata_val = pipe_val[RAM_PIPE_STAGE-1];

endmodule

`default_nettype wire

// File: verilog/deint_fwft_prefetch.sv
`timescale 1ns/100ps
`default_nettype none

module deint_fwft_prefetch
   import deint_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      avail,
   input  deint_rd_t in_word,
   input  logic      in_val,
   input  logic      rd_en,
   output logic      fetch,
   output logic      pop,
   output deint_rd_t rd,
   output logic      rd_val,
   output logic      udf_int
);

   deint_rd_t               slot [PRE_SLOT_NUM];
   logic [PRE_SLOT_NUM-1:0] slot_val;
   logic [PRE_SLOT_NUM-1:0] issue_ring;               // next slot to reserve
   logic [PRE_SLOT_NUM-1:0] issue_dly [RAM_PIPE_STAGE+1];
   logic [PRE_SLOT_NUM-1:0] fill_ring;                // slot for returning data
   logic [PRE_SLOT_NUM-1:0] out_ring;                 // oldest word

   // only fetch into a slot that is already drained
   assign fetch     = avail & ~|(issue_ring & slot_val);
   assign rd_val    = |(slot_val & out_ring);
   assign pop       = rd_en & rd_val;
   assign fill_ring = issue_dly[RAM_PIPE_STAGE];

   // ----------------------------------------
   // rings
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issue_ring <= PRE_SLOT_NUM'(1);
         out_ring   <= PRE_SLOT_NUM'(1);
      end else begin
         if (fetch)
            issue_ring <= {issue_ring[PRE_SLOT_NUM-2:0], issue_ring[PRE_SLOT_NUM-1]};
         if (pop)
            out_ring <= {out_ring[PRE_SLOT_NUM-2:0], out_ring[PRE_SLOT_NUM-1]};
      end
   end

   // issue ring delayed by the read latency, address register included
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int s = 0; s <= RAM_PIPE_STAGE; s++)
            issue_dly[s] <= PRE_SLOT_NUM'(1);
      end else begin
         issue_dly[0] <= issue_ring;
         for (int s = 1; s <= RAM_PIPE_STAGE; s++)
            issue_dly[s] <= issue_dly[s-1];
      end
   end

   // ----------------------------------------
   // slots
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_val <= '0;
      end else begin
         for (int i = 0; i < PRE_SLOT_NUM; i++) begin
            if (in_val && fill_ring[i])
               slot_val[i] <= 1'b1;
            else if (pop && out_ring[i])
               slot_val[i] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < PRE_SLOT_NUM; i++) begin
         if (in_val && fill_ring[i])
            slot[i] <= in_word;
      end
   end

   always_comb begin
      rd = slot[0];
      for (int i = 1; i < PRE_SLOT_NUM; i++) begin
         if (out_ring[i])
            rd = slot[i];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         udf_int <= 1'b0;
      else
         udf_int <= rd_en & ~rd_val;   // read with nothing to show
   end

endmodule

`default_nettype wire

// File: verilog/deint_fifo_top.sv
`timescale 1ns/100ps
`default_nettype none

module deint_fifo_top
   import deint_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  deint_wr_t     wr,
   input  deint_cfg_t    cfg,
   input  logic          rd_en,
   output deint_rd_t     rd,
   output logic          rd_val,
   output deint_status_t status
);

   logic [CODE_WIDTH-1:0] wcode;      // encoded write word
   logic                  wen;
   logic [ADDR_WIDTH-1:0] waddr;
   logic [ADDR_WIDTH-1:0] raddr;
   logic                  avail;
   logic                  fetch;
   logic                  pop;
   logic [CODE_WIDTH-1:0] rcode;
   logic                  rcode_val;
   deint_rd_t             rword;      // decoded ram output

   // ----------------------------------------
   // input side
   // ----------------------------------------
   deint_secded_enc i_enc (
      .wr   (wr),
      .code (wcode)
   );

   deint_fifo_ctrl i_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (wr.en),
      .pop       (pop),
      .fetch     (fetch),
      .cfg       (cfg),
      .wen       (wen),
      .waddr     (waddr),
      .raddr     (raddr),
      .avail     (avail),
      .full      (status.full),
      .prog_full (status.prog_full),
      .ovf_int   (status.ovf_int)
   );

   // ----------------------------------------
   // memory
   // ----------------------------------------
   deint_ram i_ram (
      .clk       (clk),
      .rst_n     (rst_n),
      .wen       (wen),
      .waddr     (waddr),
      .wdata     (wcode),
      .ren       (fetch),
      .raddr     (raddr),
      .rdata     (rcode),
      .rdata_val (rcode_val)
   );

   // ----------------------------------------
   // output side
   // ----------------------------------------
   deint_secded_dec i_dec (
      .code (rcode),
      .word (rword)
   );

   deint_fwft_prefetch i_pre (
      .clk     (clk),
      .rst_n   (rst_n),
      .avail   (avail),
      .in_word (rword),
      .in_val  (rcode_val),
      .rd_en   (rd_en),
      .fetch   (fetch),
      .pop     (pop),
      .rd      (rd),
      .rd_val  (rd_val),
      .udf_int (status.udf_int)
   );

endmodule

`default_nettype wire

// File: test/deint_fifo_tb.sv
`timescale 1ns/100ps
`default_nettype none

module deint_fifo_tb
   import deint_pkg::*;
();

   localparam int CLK_PERIOD = 10;
   localparam int STREAM_LEN = 400;
   localparam int ECC_LEN    = 48;                   // multiple of 3, one third per inject code
   localparam int PF_OPS     = 260;
   localparam int TOTAL_OPS  = 16 + STREAM_LEN + 2 * FIFO_DEPTH + 4 + PF_OPS + ECC_LEN + 8;

   logic          clk;
   logic          rst_n;
   deint_wr_t     wr;
   deint_cfg_t    cfg;
   logic          rd_en;
   deint_rd_t     rd;
   logic          rd_val;
   deint_status_t status;

   deint_rd_t     ref_q [$];                         // words accepted, not yet popped
   int            model_level;
   logic          model_pf;
   logic          model_ovf;
   logic          model_udf;
   logic          hold_valid;                        // rd shown last cycle without rd_en
   deint_rd_t     hold_word;
   int            ovf_seen;
   int            udf_seen;
   int            sgl_seen;
   int            dbl_seen;
   int            checks;
   int            errors;
   int            err_base;
   int            test_num;
   int            tests_failed;
   logic [31:0]   rng_state;

   deint_fifo_top i_dut (
      .clk    (clk),
      .rst_n  (rst_n),
      .wr     (wr),
      .cfg    (cfg),
      .rd_en  (rd_en),
      .rd     (rd),
      .rd_val (rd_val),
      .status (status)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // reference model of one word through encode, store and decode
   function automatic deint_rd_t expect_word(input logic [DATA_WIDTH-1:0] data,
                                             input err_inject_e inject);
      deint_rd_t w;
      w.data       = data;
      w.single_err = (inject == INJ_SINGLE);   // parity bit flip, data intact
      w.double_err = (inject == INJ_DOUBLE);
      return w;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   task automatic next_rand(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r         = rng_state;
   endtask

   task automatic next_word(output logic [DATA_WIDTH-1:0] w);
      logic [31:0] lo;
      logic [31:0] hi;
      next_rand(lo);
      next_rand(hi);
      w = {hi, lo};
   endtask

   task automatic start_test();
      test_num++;
      err_base = errors;
   endtask

   task automatic end_test(input string name);
      if (errors != err_base)
         tests_failed++;
      $display("test %0d %s: %s (%0d errors)", test_num, name,
               (errors == err_base) ? "ok" : "failed", errors - err_base);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         wr.en = 1'b0;
         rd_en = 1'b0;
      end
   endtask

   // one write or one read request per cycle until the model level hits target
   task automatic move_level(input int target);
      logic [DATA_WIDTH-1:0] w;
      forever begin
         @(negedge clk);
         if (model_level == target) begin
            wr.en = 1'b0;
            rd_en = 1'b0;
            break;
         end
         if (model_level < target) begin
            next_word(w);
            wr.data   = w;
            wr.inject = INJ_NONE;
            wr.en     = 1'b1;
            rd_en     = 1'b0;
         end else begin
            wr.en = 1'b0;
            rd_en = 1'b1;
         end
      end
   endtask

   task automatic drain_all();
      forever begin
         @(negedge clk);
         wr.en = 1'b0;
         if (ref_q.size() == 0 && model_level == 0) begin
            rd_en = 1'b0;
            break;
         end
         rd_en = 1'b1;
      end
   endtask

   // ----------------------------------------
   // comparator and flag model
   // ----------------------------------------
   always @(posedge clk) begin : monitor
      deint_rd_t exp;
      logic      acc;
      logic      popped;
      if (!rst_n) begin
         ref_q.delete();
         model_level = 0;
         model_pf    = 1'b0;
         model_ovf   = 1'b0;
         model_udf   = 1'b0;
         hold_valid  = 1'b0;
      end else begin
         popped = rd_en && rd_val;
         acc    = wr.en && (model_level != FIFO_DEPTH);
         check_value("status.full", status.full, model_level == FIFO_DEPTH);
         check_value("status.prog_full", status.prog_full, model_pf);
         check_value("status.ovf_int", status.ovf_int, model_ovf);
         check_value("status.udf_int", status.udf_int, model_udf);
         if (status.ovf_int)
            ovf_seen++;
         if (status.udf_int)
            udf_seen++;
         if (hold_valid) begin
            check_value("rd_val", rd_val, 1'b1);
            check_value("rd.data", rd.data, hold_word.data);
            check_value("rd.flags", {rd.single_err, rd.double_err},
                        {hold_word.single_err, hold_word.double_err});
         end
         if (popped) begin
            if (ref_q.size() == 0) begin
               report_failure("word popped while the reference queue is empty");
            end else begin
               exp = ref_q.pop_front();
               check_value("rd.single_err", rd.single_err, exp.single_err);
               check_value("rd.double_err", rd.double_err, exp.double_err);
               if (!exp.double_err)
                  check_value("rd.data", rd.data, exp.data);   // uncorrectable data is don't care
               if (rd.single_err)
                  sgl_seen++;
               if (rd.double_err)
                  dbl_seen++;
            end
         end
         if (acc)
            ref_q.push_back(expect_word(wr.data, wr.inject));
         model_ovf   = wr.en && (model_level == FIFO_DEPTH);
         model_udf   = rd_en && !rd_val;
         model_level = model_level + int'(acc) - int'(popped);
         if (model_level >= cfg.full_assert)
            model_pf = 1'b1;
         else if (model_level <= cfg.full_negate)
            model_pf = 1'b0;
         hold_valid = rd_val && !rd_en;
         hold_word  = rd;
      end
   end

   // ----------------------------------------
   // tests
   // ----------------------------------------
   task automatic test_fwft();
      logic [DATA_WIDTH-1:0] w;
      int                    n;
      start_test();
      @(negedge clk);
      check_value("rd_val", rd_val, 1'b0);
      check_value("status", status, '0);
      next_word(w);
      wr.data   = w;
      wr.inject = INJ_NONE;
      wr.en     = 1'b1;
      @(posedge clk);                                  // write edge
      @(negedge clk);
      wr.en = 1'b0;
      n     = 0;
      while (!rd_val && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (!rd_val)
         report_failure("rd_val never rose after a single write");
      check_value("fwft latency", n, 4);
      check_value("rd.data", rd.data, w);              // visible with rd_en low
      check_value("rd.flags", {rd.single_err, rd.double_err}, 2'b00);
      drain_all();
      end_test("reset and first word fall through");
   endtask

   task automatic test_stream();
      logic [DATA_WIDTH-1:0] w;
      logic [31:0]           r;
      start_test();
      for (int i = 0; i < STREAM_LEN; i++) begin
         @(negedge clk);
         next_word(w);
         next_rand(r);
         wr.data   = w;
         wr.inject = INJ_NONE;
         wr.en     = r[0] | (r[1] & r[2]);
         rd_en     = r[3];
      end
      drain_all();
      end_test("streaming order");
   endtask

   task automatic test_fill();
      int ovf_base;
      start_test();
      move_level(FIFO_DEPTH);
      check_value("status.full", status.full, 1'b1);
      ovf_base = ovf_seen;
      @(negedge clk);
      wr.data = '1;
      wr.en   = 1'b1;                                  // dropped
      idle(3);
      check_value("ovf pulses", ovf_seen - ovf_base, 1);
      check_value("status.full", status.full, 1'b1);   // level untouched by the drop
      drain_all();
      check_value("status.full", status.full, 1'b0);
      end_test("fill to full and overflow");
   endtask

   task automatic test_prog_full();
      start_test();
      move_level(105);
      check_value("prog_full at 105", status.prog_full, 1'b1);
      move_level(95);
      check_value("prog_full at 95 falling", status.prog_full, 1'b1);
      move_level(85);
      check_value("prog_full at 85", status.prog_full, 1'b0);
      move_level(95);
      check_value("prog_full at 95 rising", status.prog_full, 1'b0);
      move_level(101);
      check_value("prog_full at 101", status.prog_full, 1'b1);
      drain_all();
      check_value("prog_full empty", status.prog_full, 1'b0);
      end_test("programmable full hysteresis");
   endtask

   task automatic test_ecc();
      logic [DATA_WIDTH-1:0] w;
      logic [31:0]           r;
      int                    sgl_base;
      int                    dbl_base;
      start_test();
      sgl_base = sgl_seen;
      dbl_base = dbl_seen;
      for (int i = 0; i < ECC_LEN; i++) begin
         @(negedge clk);
         next_word(w);
         next_rand(r);
         wr.data   = w;
         wr.inject = err_inject_e'(i % 3);
         wr.en     = 1'b1;
         rd_en     = r[0];
      end
      drain_all();
      wr.inject = INJ_NONE;
      check_value("single_err words", sgl_seen - sgl_base, ECC_LEN / 3);
      check_value("double_err words", dbl_seen - dbl_base, ECC_LEN / 3);
      end_test("secded correction and detection");
   endtask

   task automatic test_underflow();
      int udf_base;
      start_test();
      idle(2);
      udf_base = udf_seen;
      check_value("rd_val", rd_val, 1'b0);
      @(negedge clk);
      rd_en = 1'b1;
      idle(3);
      check_value("udf pulses", udf_seen - udf_base, 1);
      check_value("model level", model_level, 0);
      check_value("rd_val", rd_val, 1'b0);            // nothing appears after the empty read
      end_test("underflow");
   endtask

   initial begin : stimulus
      rng_state    = 32'd35239;
      rst_n        = 1'b0;
      wr           = '0;
      rd_en        = 1'b0;
      cfg          = '{full_assert: LEVEL_WIDTH'(100), full_negate: LEVEL_WIDTH'(90)};
      checks       = 0;
      errors       = 0;
      test_num     = 0;
      tests_failed = 0;
      ovf_seen     = 0;
      udf_seen     = 0;
      sgl_seen     = 0;
      dbl_seen     = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_fwft();
      test_stream();
      test_fill();
      test_prog_full();
      test_ecc();
      test_underflow();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_num, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // bound derived from the operation count of all tests
   initial begin : watchdog
      #(TOTAL_OPS * 20 * CLK_PERIOD + 2000);
      $display("timeout: the tests did not finish in %0d cycles", TOTAL_OPS * 20);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
verilog/deint_pkg.sv
verilog/deint_secded_enc.sv
verilog/deint_secded_dec.sv
verilog/deint_fifo_ctrl.sv
verilog/deint_ram.sv
verilog/deint_fwft_prefetch.sv
verilog/deint_fifo_top.sv
test/deint_fifo_tb.sv

// File: Bender.yml
package:
  name: deint_fifo

sources:
  - verilog/deint_pkg.sv
  - verilog/deint_secded_enc.sv
  - verilog/deint_secded_dec.sv
  - verilog/deint_fifo_ctrl.sv
  - verilog/deint_ram.sv
  - verilog/deint_fwft_prefetch.sv
  - verilog/deint_fifo_top.sv
  - target: test
    files:
      - test/deint_fifo_tb.sv
